//--- Bender.yml
package:
  name: fncp_cluster

sources:
  - fncp_pkg.sv
  - fp_classifier.sv
  - fncp_lane.sv
  - fncp_dispatch.sv
  - fncp_collect.sv
  - fncp_cluster.sv
  - target: test
    files:
      - fncp_cluster_properties.sv
      - tb_fncp_cluster.sv

//--- fncp_cluster.f
fncp_pkg.sv
fp_classifier.sv
fncp_lane.sv
fncp_dispatch.sv
fncp_collect.sv
fncp_cluster.sv
fncp_cluster_properties.sv
tb_fncp_cluster.sv

//--- fncp_cluster.sv
`timescale 1ns/100ps

module fncp_cluster #(
    parameter int NUM_LANES = fncp_pkg::NUM_LANES_DEF,
    parameter int LATENCY   = 2
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              in_valid,
    output logic                              in_ready,
    input  fncp_pkg::fncp_req_t               in_req,
    input  fncp_pkg::fp32_t [NUM_LANES-1:0]   in_a,
    input  fncp_pkg::fp32_t [NUM_LANES-1:0]   in_b,
    input  fncp_pkg::fncp_tag_t               in_tag,
    output logic                              out_valid,
    input  logic                              out_ready,
    output fncp_pkg::fp32_t [NUM_LANES-1:0]   out_result,
    output fncp_pkg::fp_flags_t               out_fflags,
    output fncp_pkg::fncp_tag_t               out_tag
);

    logic                            enable;
    fncp_pkg::op_mod_t               op_mod;
    logic                            pipe_valid;
    logic [NUM_LANES-1:0]            pipe_mask;
    fncp_pkg::fncp_tag_t             pipe_tag;
    fncp_pkg::fp32_t [NUM_LANES-1:0] lane_result;
    logic [NUM_LANES-1:0]            lane_nv;

    assign in_ready = enable;

    fncp_dispatch #(
        .NUM_LANES (NUM_LANES),
        .LATENCY   (LATENCY)
    ) u_dispatch (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .in_tag     (in_tag),
        .op_mod     (op_mod),
        .pipe_valid (pipe_valid),
        .pipe_mask  (pipe_mask),
        .pipe_tag   (pipe_tag)
    );

    // All lanes share one opcode and one enable
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        fncp_lane #(
            .LATENCY (LATENCY)
        ) u_lane (
            .clk    (clk),
            .rst    (rst),
            .enable (enable),
            .op_mod (op_mod),
            .a      (in_a[i]),
            .b      (in_b[i]),
            .result (lane_result[i]),
            .nv     (lane_nv[i])
        );
    end

    fncp_collect #(
        .NUM_LANES (NUM_LANES)
    ) u_collect (
        .out_ready   (out_ready),
        .pipe_valid  (pipe_valid),
        .pipe_mask   (pipe_mask),
        .pipe_tag    (pipe_tag),
        .lane_result (lane_result),
        .lane_nv     (lane_nv),
        .enable      (enable),
        .out_valid   (out_valid),
        .out_result  (out_result),
        .out_fflags  (out_fflags),
        .out_tag     (out_tag)
    );

endmodule

//--- fncp_cluster_properties.sv
`timescale 1ns/100ps

module fncp_cluster_properties #(
    parameter int NUM_LANES = fncp_pkg::NUM_LANES_DEF,
    parameter int LATENCY   = 2
) (
    input logic                            clk,
    input logic                            rst,
    input logic                            in_valid,
    input logic                            in_ready,
    input logic                            out_valid,
    input logic                            out_ready,
    input fncp_pkg::fp32_t [NUM_LANES-1:0] out_result,
    input fncp_pkg::fp_flags_t             out_fflags,
    input fncp_pkg::fncp_tag_t             out_tag
);

    // Valid pipeline is cleared by reset
    assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    // A held beat stays put until it is taken
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_result) && $stable(out_tag)
            && $stable(out_fflags))
        else $error("Held output beat changed before out_ready");

    assert property (@(posedge clk) disable iff (rst)
        in_ready == !(out_valid && !out_ready))
        else $error("in_ready does not follow the output occupancy");

    // Once accepted, a beat reaches the output LATENCY edges later
    assert property (@(posedge clk) disable iff (rst)
        in_valid && in_ready && out_ready |-> ##LATENCY out_valid)
        else $error("Accepted beat did not reach the output in time");

endmodule

//--- fncp_collect.sv
`timescale 1ns/100ps

module fncp_collect #(
    parameter int NUM_LANES = fncp_pkg::NUM_LANES_DEF
) (
    input  logic                              out_ready,
    input  logic                              pipe_valid,
    input  logic [NUM_LANES-1:0]              pipe_mask,
    input  fncp_pkg::fncp_tag_t               pipe_tag,
    input  fncp_pkg::fp32_t [NUM_LANES-1:0]   lane_result,
    input  logic [NUM_LANES-1:0]              lane_nv,
    output logic                              enable,
    output logic                              out_valid,
    output fncp_pkg::fp32_t [NUM_LANES-1:0]   out_result,
    output fncp_pkg::fp_flags_t               out_fflags,
    output fncp_pkg::fncp_tag_t               out_tag
);

    logic nv_any;

    // Last lane stage is the output holding register
    assign out_valid = pipe_valid;
    assign out_tag   = pipe_tag;

    // Move on when nothing is held or the held beat leaves this cycle
    assign enable = ~pipe_valid | out_ready;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            out_result[i] = pipe_mask[i] ? lane_result[i] : '0;
        end
    end

    // Masked lanes never raise a flag
    assign nv_any = |(lane_nv & pipe_mask);

    // Only NV can occur here
    assign out_fflags = {nv_any, 4'b0000};

endmodule

//--- fncp_dispatch.sv
`timescale 1ns/100ps

module fncp_dispatch #(
    parameter int NUM_LANES = fncp_pkg::NUM_LANES_DEF,
    parameter int LATENCY   = 2
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enable,
    input  logic                  in_valid,
    input  fncp_pkg::fncp_req_t   in_req,
    input  fncp_pkg::fncp_tag_t   in_tag,
    output fncp_pkg::op_mod_t     op_mod,
    output logic                  pipe_valid,
    output logic [NUM_LANES-1:0]  pipe_mask,
    output fncp_pkg::fncp_tag_t   pipe_tag
);

    typedef struct packed {
        logic [NUM_LANES-1:0] mask;
        fncp_pkg::fncp_tag_t  tag;
    } meta_t;

    logic [LATENCY-1:0] valid_q;
    meta_t              meta_q [LATENCY];

    // Map the opcode onto the lane's variant encoding
    always_comb begin
        case (in_req.op)
            fncp_pkg::OP_SGNJ:   op_mod = {1'b0, in_req.frm};
            fncp_pkg::OP_CMP:    op_mod = {1'b1, in_req.frm};
            fncp_pkg::OP_CLASS:  op_mod = 4'd3;
            fncp_pkg::OP_MV:     op_mod = {2'b01, 1'b0, in_req.frm[0]};
            fncp_pkg::OP_MINMAX: op_mod = {2'b01, 1'b1, in_req.frm[0]};
            default:             op_mod = {1'b0, in_req.frm};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (enable) begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < LATENCY; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // Mask and tag ride alongside, no reset needed
    always_ff @(posedge clk) begin
        if (enable) begin
            meta_q[0].mask <= in_req.mask[NUM_LANES-1:0];
            meta_q[0].tag  <= in_tag;
            for (int i = 1; i < LATENCY; i++) begin
                meta_q[i] <= meta_q[i-1];
            end
        end
    end

    assign pipe_valid = valid_q[LATENCY-1];
    assign pipe_mask  = meta_q[LATENCY-1].mask;
    assign pipe_tag   = meta_q[LATENCY-1].tag;

endmodule

//--- fncp_lane.sv
`timescale 1ns/100ps

module fncp_lane #(
    parameter int LATENCY = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              enable,
    input  fncp_pkg::op_mod_t op_mod,
    input  fncp_pkg::fp32_t   a,
    input  fncp_pkg::fp32_t   b,
    output fncp_pkg::fp32_t   result,
    output logic              nv
);

    typedef struct packed {
        fncp_pkg::op_mod_t op_mod;
        fncp_pkg::fp32_t   a;
        fncp_pkg::fp32_t   b;
        fncp_pkg::fclass_t a_class;
        fncp_pkg::fclass_t b_class;
        logic              a_smaller;
        logic              ab_equal;
    } stage0_t;

    fncp_pkg::fclass_t a_class;
    fncp_pkg::fclass_t b_class;
    stage0_t           s0_d;
    stage0_t           s0_q;
    fncp_pkg::fp32_t   class_mask;
    fncp_pkg::fp32_t   minmax_res;
    fncp_pkg::fp32_t   sgnj_res;
    logic              cmp_res;
    logic              cmp_nv;
    logic              any_nan;
    logic              any_snan;
    fncp_pkg::fp32_t   result_d;
    logic              nv_d;

    fp_classifier u_class_a (
        .exponent (a[30:23]),
        .mantissa (a[22:0]),
        .fclass   (a_class)
    );

    fp_classifier u_class_b (
        .exponent (b[30:23]),
        .mantissa (b[22:0]),
        .fclass   (b_class)
    );

    always_comb begin
        s0_d.op_mod    = op_mod;
        s0_d.a         = a;
        s0_d.b         = b;
        s0_d.a_class   = a_class;
        s0_d.b_class   = b_class;
        // Raw unsigned order flipped once either value is negative
        s0_d.a_smaller = (a < b) ^ (a[31] | b[31]);
        // +0 equals -0
        s0_d.ab_equal  = (a == b) || (a_class.is_zero && b_class.is_zero);
    end

    // Stage 0 register only exists for the two-cycle configuration
    if (LATENCY > 1) begin : g_stage0_reg
        always_ff @(posedge clk) begin
            if (enable) begin
                s0_q <= s0_d;
            end
        end
    end else begin : g_stage0_comb
        assign s0_q = s0_d;
    end

    assign any_nan  = s0_q.a_class.is_nan | s0_q.b_class.is_nan;
    assign any_snan = s0_q.a_class.is_signaling | s0_q.b_class.is_signaling;

    always_comb begin
        if (s0_q.a_class.is_normal) begin
            class_mask = s0_q.a[31] ? fncp_pkg::NEG_NORM : fncp_pkg::POS_NORM;
        end else if (s0_q.a_class.is_inf) begin
            class_mask = s0_q.a[31] ? fncp_pkg::NEG_INF : fncp_pkg::POS_INF;
        end else if (s0_q.a_class.is_zero) begin
            class_mask = s0_q.a[31] ? fncp_pkg::NEG_ZERO : fncp_pkg::POS_ZERO;
        end else if (s0_q.a_class.is_subnormal) begin
            class_mask = s0_q.a[31] ? fncp_pkg::NEG_SUBNORM : fncp_pkg::POS_SUBNORM;
        end else begin
            class_mask = s0_q.a_class.is_quiet ? fncp_pkg::QUIET_NAN : fncp_pkg::SIG_NAN;
        end
    end

    // Variant bit 0 picks max
    // A NaN operand loses to a number
    always_comb begin
        if (s0_q.a_class.is_nan && s0_q.b_class.is_nan) begin
            minmax_res = fncp_pkg::QNAN_CANON;
        end else if (s0_q.a_class.is_nan) begin
            minmax_res = s0_q.b;
        end else if (s0_q.b_class.is_nan) begin
            minmax_res = s0_q.a;
        end else begin
            minmax_res = (s0_q.op_mod[0] ^ s0_q.a_smaller) ? s0_q.a : s0_q.b;
        end
    end

    always_comb begin
        case (s0_q.op_mod[1:0])
            2'd0:    sgnj_res = {s0_q.b[31], s0_q.a[30:0]};
            2'd1:    sgnj_res = {~s0_q.b[31], s0_q.a[30:0]};
            default: sgnj_res = {s0_q.a[31] ^ s0_q.b[31], s0_q.a[30:0]};
        endcase
    end

    // LE and LT signal on any NaN and EQ on signaling NaN only
    always_comb begin
        cmp_res = 1'b0;
        cmp_nv  = 1'b0;
        case (s0_q.op_mod[1:0])
            2'd0: begin
                cmp_res = !any_nan && (s0_q.a_smaller || s0_q.ab_equal);
                cmp_nv  = any_nan;
            end
            2'd1: begin
                cmp_res = !any_nan && s0_q.a_smaller && !s0_q.ab_equal;
                cmp_nv  = any_nan;
            end
            2'd2: begin
                cmp_res = !any_nan && s0_q.ab_equal;
                cmp_nv  = any_snan;
            end
            default: begin
                cmp_res = 1'b0;
                cmp_nv  = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (s0_q.op_mod[2:0])
            3'd0, 3'd1, 3'd2: begin
                result_d = s0_q.op_mod[3] ? {31'd0, cmp_res} : sgnj_res;
                nv_d     = s0_q.op_mod[3] & cmp_nv;
            end
            3'd3: begin
                result_d = class_mask;
                nv_d     = 1'b0;
            end
            3'd4, 3'd5: begin
                result_d = s0_q.a;
                nv_d     = 1'b0;
            end
            default: begin
                result_d = minmax_res;
                nv_d     = any_snan;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            result <= result_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            nv <= 1'b0;
        end else if (enable) begin
            nv <= nv_d;
        end
    end

endmodule

//--- fncp_pkg.sv
package fncp_pkg;

    // Lane count used when the top level keeps its default
    localparam int NUM_LANES_DEF = 4;

    typedef logic [31:0] fp32_t;
    // NV, DZ, OF, UF, NX from bit 4 down to bit 0
    typedef logic [4:0] fp_flags_t;
    typedef logic [2:0] frm_t;
    // Compare flag on top of the 3-bit variant code
    typedef logic [3:0] op_mod_t;
    typedef logic [7:0] fncp_tag_t;

    typedef enum logic [2:0] {
        OP_SGNJ   = 3'd0,
        OP_CMP    = 3'd1,
        OP_CLASS  = 3'd2,
        OP_MV     = 3'd3,
        OP_MINMAX = 3'd4
    } fncp_op_e;

    typedef struct packed {
        logic is_normal;
        logic is_zero;
        logic is_subnormal;
        logic is_inf;
        logic is_nan;
        logic is_quiet;
        logic is_signaling;
    } fclass_t;

    // FCLASS result, one hot over ten categories
    localparam fp32_t NEG_INF     = 32'h0000_0001;
    localparam fp32_t NEG_NORM    = 32'h0000_0002;
    localparam fp32_t NEG_SUBNORM = 32'h0000_0004;
    localparam fp32_t NEG_ZERO    = 32'h0000_0008;
    localparam fp32_t POS_ZERO    = 32'h0000_0010;
    localparam fp32_t POS_SUBNORM = 32'h0000_0020;
    localparam fp32_t POS_NORM    = 32'h0000_0040;
    localparam fp32_t POS_INF     = 32'h0000_0080;
    localparam fp32_t SIG_NAN     = 32'h0000_0100;
    localparam fp32_t QUIET_NAN   = 32'h0000_0200;

    localparam fp32_t QNAN_CANON = 32'h7fc0_0000;

    // Mask is sized for the default lane count
    typedef struct packed {
        fncp_op_e                 op;
        frm_t                     frm;
        logic [NUM_LANES_DEF-1:0] mask;
    } fncp_req_t;

endpackage

//--- fp_classifier.sv
`timescale 1ns/100ps

module fp_classifier (
    input  logic [7:0]        exponent,
    input  logic [22:0]       mantissa,
    output fncp_pkg::fclass_t fclass
);

    logic exp_zero;
    logic exp_ones;
    logic man_zero;

    assign exp_zero = (exponent == 8'h00);
    assign exp_ones = (exponent == 8'hff);
    assign man_zero = (mantissa == 23'd0);

    always_comb begin
        fclass.is_normal    = !exp_zero && !exp_ones;
        fclass.is_zero      = exp_zero && man_zero;
        fclass.is_subnormal = exp_zero && !man_zero;
        fclass.is_inf       = exp_ones && man_zero;
        fclass.is_nan       = exp_ones && !man_zero;
        // Top mantissa bit tells quiet from signaling
        fclass.is_quiet     = exp_ones && !man_zero && mantissa[22];
        fclass.is_signaling = exp_ones && !man_zero && !mantissa[22];
    end

endmodule

//--- tb_fncp_cluster.sv
`timescale 1ns/100ps

module tb_fncp_cluster;

    localparam int NUM_LANES       = 4;
    localparam int LATENCY         = 2;
    localparam int N_SGNJ          = 32;
    localparam int N_CMP           = 48;
    localparam int N_CLASS         = 32;
    localparam int N_MINMAX        = 40;
    localparam int N_MASK          = 32;
    localparam int N_STRESS        = 96;
    localparam int TOTAL_BEATS     = N_SGNJ + N_CMP + N_CLASS + N_MINMAX + N_MASK + N_STRESS;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 20 + 200;

    // One scoreboard entry per accepted beat
    typedef struct packed {
        fncp_pkg::fncp_tag_t             tag;
        fncp_pkg::fp32_t [NUM_LANES-1:0] result;
        fncp_pkg::fp_flags_t             fflags;
    } expect_t;

    logic                            clk;
    logic                            rst;
    logic                            in_valid;
    logic                            in_ready;
    fncp_pkg::fncp_req_t             in_req;
    fncp_pkg::fp32_t [NUM_LANES-1:0] in_a;
    fncp_pkg::fp32_t [NUM_LANES-1:0] in_b;
    fncp_pkg::fncp_tag_t             in_tag;
    logic                            out_valid;
    logic                            out_ready;
    fncp_pkg::fp32_t [NUM_LANES-1:0] out_result;
    fncp_pkg::fp_flags_t             out_fflags;
    fncp_pkg::fncp_tag_t             out_tag;

    integer              seed = 32'h4258_81db;
    logic                bp_on;
    logic [31:0]         ready_draw;
    fncp_pkg::fncp_tag_t tag_next;
    int                  err_count;
    int                  check_count;
    int                  tx_count;
    int                  rx_count;
    expect_t             exp_q[$];

    fncp_cluster #(
        .NUM_LANES (NUM_LANES),
        .LATENCY   (LATENCY)
    ) dut0 (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_req     (in_req),
        .in_a       (in_a),
        .in_b       (in_b),
        .in_tag     (in_tag),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result),
        .out_fflags (out_fflags),
        .out_tag    (out_tag)
    );

    bind fncp_cluster fncp_cluster_properties #(
        .NUM_LANES (NUM_LANES),
        .LATENCY   (LATENCY)
    ) u_props (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result),
        .out_fflags (out_fflags),
        .out_tag    (out_tag)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic nan_of(fncp_pkg::fp32_t x);
        return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
    endfunction

    function automatic logic snan_of(fncp_pkg::fp32_t x);
        return nan_of(x) && !x[22];
    endfunction

    function automatic logic zero_of(fncp_pkg::fp32_t x);
        return x[30:0] == 31'd0;
    endfunction

    // Ordered less-than on non-NaN values with the two zeros equal
    function automatic logic less_of(fncp_pkg::fp32_t a, fncp_pkg::fp32_t b);
        if (zero_of(a) && zero_of(b)) begin
            return 1'b0;
        end
        if (a[31] != b[31]) begin
            return a[31];
        end
        return a[31] ? (a[30:0] > b[30:0]) : (a[30:0] < b[30:0]);
    endfunction

    function automatic fncp_pkg::fp32_t class_of(fncp_pkg::fp32_t x);
        if (x[30:23] == 8'hff) begin
            if (x[22:0] == 23'd0) begin
                return x[31] ? 32'h001 : 32'h080;
            end
            return x[22] ? 32'h200 : 32'h100;
        end
        if (x[30:23] == 8'h00) begin
            if (x[22:0] == 23'd0) begin
                return x[31] ? 32'h008 : 32'h010;
            end
            return x[31] ? 32'h004 : 32'h020;
        end
        return x[31] ? 32'h002 : 32'h040;
    endfunction

    // Expected {nv, result} of one lane
    function automatic logic [32:0] fncp_ref(fncp_pkg::fncp_op_e op, fncp_pkg::frm_t frm,
                                             fncp_pkg::fp32_t a, fncp_pkg::fp32_t b);
        logic nan_ab;
        logic snan_ab;
        logic lt;
        logic eq;
        logic a_below;
        nan_ab  = nan_of(a) || nan_of(b);
        snan_ab = snan_of(a) || snan_of(b);
        lt      = less_of(a, b);
        eq      = (a == b) || (zero_of(a) && zero_of(b));
        // For min/max the negative zero sits below the positive one
        a_below = lt || (zero_of(a) && zero_of(b) && a[31] && !b[31]);
        case (op)
            fncp_pkg::OP_SGNJ: begin
                if (frm == 3'd0) return {1'b0, b[31], a[30:0]};
                if (frm == 3'd1) return {1'b0, ~b[31], a[30:0]};
                return {1'b0, a[31] ^ b[31], a[30:0]};
            end
            fncp_pkg::OP_CMP: begin
                if (frm == 3'd0) return {nan_ab, 31'd0, !nan_ab && (lt || eq)};
                if (frm == 3'd1) return {nan_ab, 31'd0, !nan_ab && lt};
                return {snan_ab, 31'd0, !nan_ab && eq};
            end
            fncp_pkg::OP_CLASS: return {1'b0, class_of(a)};
            fncp_pkg::OP_MV:    return {1'b0, a};
            default: begin
                if (nan_of(a) && nan_of(b)) return {snan_ab, 32'h7fc0_0000};
                if (nan_of(a)) return {snan_ab, b};
                if (nan_of(b)) return {snan_ab, a};
                if (frm[0]) return {snan_ab, a_below ? b : a};
                return {snan_ab, a_below ? a : b};
            end
        endcase
    endfunction

    // Random values mixed with zeros, infinities, subnormals and NaNs
    function automatic fncp_pkg::fp32_t pick_operand();
        logic [31:0] r;
        logic [31:0] v;
        r = $random(seed);
        v = $random(seed);
        case (r[3:0])
            4'd0:    return 32'h0000_0000;
            4'd1:    return 32'h8000_0000;
            4'd2:    return 32'h7f80_0000;
            4'd3:    return 32'hff80_0000;
            4'd4:    return {v[31], 8'h00, v[22:0] | 23'd1};
            4'd5:    return {v[31], 8'hff, 1'b1, v[21:0]};
            4'd6:    return {v[31], 8'hff, 1'b0, v[21:0] | 22'd1};
            default: return v;
        endcase
    endfunction

    // op_sel is a fixed opcode, -1 for any, -2 for MV or MINMAX
    task automatic run_test(input string name, input int op_sel, input int beats,
                            input logic rand_mask, input logic stress);
        int                  err_start;
        logic [31:0]         r;
        logic [31:0]         pair_draw;
        fncp_pkg::fncp_op_e  op;
        fncp_pkg::frm_t      frm;
        fncp_pkg::fncp_req_t req;
        fncp_pkg::fp32_t     a;
        err_start = err_count;
        bp_on <= stress;
        for (int n = 0; n < beats; n++) begin
            r = $random(seed);
            if (op_sel >= 0) begin
                op = fncp_pkg::fncp_op_e'(3'(op_sel));
            end else if (op_sel == -2) begin
                op = r[12] ? fncp_pkg::OP_MINMAX : fncp_pkg::OP_MV;
            end else begin
                op = fncp_pkg::fncp_op_e'(3'((r >> 12) % 5));
            end
            case (op)
                fncp_pkg::OP_SGNJ, fncp_pkg::OP_CMP: frm = 3'((r >> 4) % 3);
                fncp_pkg::OP_MV, fncp_pkg::OP_MINMAX: frm = {2'b00, r[8]};
                default: frm = 3'd0;
            endcase
            req.op   = op;
            req.frm  = frm;
            req.mask = rand_mask ? r[19:16] : 4'hf;
            for (int i = 0; i < NUM_LANES; i++) begin
                a = pick_operand();
                pair_draw = $random(seed);
                in_a[i] <= a;
                // Equal and sign-flipped pairs now and then
                if (pair_draw[1:0] == 2'd0) begin
                    in_b[i] <= a;
                end else if (pair_draw[1:0] == 2'd1) begin
                    in_b[i] <= {~a[31], a[30:0]};
                end else begin
                    in_b[i] <= pick_operand();
                end
            end
            in_valid <= 1'b1;
            in_req   <= req;
            in_tag   <= tag_next;
            tag_next++;
            @(posedge clk);
            while (!in_ready) begin
                @(posedge clk);
            end
            if (stress && r[24]) begin
                in_valid <= 1'b0;
                repeat (1 + r[26:25]) @(posedge clk);
            end
        end
        in_valid <= 1'b0;
        bp_on    <= 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        $display("%-14s %0d beats, %0d errors", name, beats, err_count - err_start);
    endtask

    // Back-pressure drawn between edges and applied on the rising edge
    always @(negedge clk) begin
        if (bp_on) begin
            ready_draw = $random(seed);
        end
    end

    always @(posedge clk) begin
        out_ready <= bp_on ? (ready_draw[1:0] != 2'b00) : 1'b1;
    end

    always @(posedge clk) begin : accept_mon
        expect_t     e;
        logic [32:0] ref_val;
        if (!rst && in_valid && in_ready) begin
            e.tag    = in_tag;
            e.fflags = '0;
            for (int i = 0; i < NUM_LANES; i++) begin
                ref_val     = fncp_ref(in_req.op, in_req.frm, in_a[i], in_b[i]);
                e.result[i] = in_req.mask[i] ? ref_val[31:0] : 32'd0;
                if (in_req.mask[i] && ref_val[32]) begin
                    e.fflags[4] = 1'b1;
                end
            end
            exp_q.push_back(e);
            tx_count++;
        end
    end

    always @(posedge clk) begin : compare_out
        expect_t e;
        if (!rst && out_valid && out_ready) begin
            rx_count++;
            assert (exp_q.size() != 0) else begin
                $display("Output beat with tag %h arrived while none was outstanding", out_tag);
                err_count++;
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                check_count++;
                assert (out_tag == e.tag) else begin
                    $display("[ERROR] out_tag expected %h got %h", e.tag, out_tag);
                    err_count++;
                end
                for (int i = 0; i < NUM_LANES; i++) begin
                    assert (out_result[i] == e.result[i]) else begin
                        $display("[ERROR] out_result[%0d] expected %h got %h",
                                 i, e.result[i], out_result[i]);
                        err_count++;
                    end
                end
                assert (out_fflags == e.fflags) else begin
                    $display("[ERROR] out_fflags expected %h got %h", e.fflags, out_fflags);
                    err_count++;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired before all beats came back");
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_req      = '0;
        in_a        = '0;
        in_b        = '0;
        in_tag      = '0;
        out_ready   = 1'b1;
        bp_on       = 1'b0;
        ready_draw  = '0;
        tag_next    = '0;
        err_count   = 0;
        check_count = 0;
        tx_count    = 0;
        rx_count    = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        run_test("sign_inject", 0, N_SGNJ, 1'b0, 1'b0);
        run_test("compare", 1, N_CMP, 1'b0, 1'b0);
        run_test("classify", 2, N_CLASS, 1'b0, 1'b0);
        run_test("minmax_move", -2, N_MINMAX, 1'b0, 1'b0);
        run_test("lane_mask", -1, N_MASK, 1'b1, 1'b0);
        run_test("backpressure", -1, N_STRESS, 1'b1, 1'b1);
        assert (rx_count == tx_count) else begin
            $display("Beats sent and received differ, %0d sent, %0d received",
                     tx_count, rx_count);
            err_count++;
        end
        $display("Summary: %0d beats, %0d checks, %0d errors", tx_count, check_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
